// ==== calc_cfg.svh ====
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// instruction memory words
`define CALC_IMEM_DEPTH 32

// word address width, log2 of the depth
`define CALC_IMEM_AW 5

// words written by one run
`define CALC_PROG_LEN 4

`endif

// ==== calc_pkg.sv ====
package calc_pkg;

	// keypad operations
	typedef enum logic [2:0] {
		cmd_add, cmd_sub, cmd_and, cmd_or, cmd_xor, cmd_sll, cmd_srl, cmd_sra
	} calc_cmd_t;

	// programmer states, one-hot
	typedef enum logic [4:0] {
		st_idle  = 5'b00001,
		st_load  = 5'b00010,
		st_write = 5'b00100,
		st_run   = 5'b01000,
		st_reset = 5'b10000
	} prog_state_t;

	typedef enum logic {cs_fetch, cs_exec} core_state_t;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_addi  = 6'h08
	} mips_op_t;

	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_sra = 6'h03,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_xor = 6'h26
	} mips_funct_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra
	} alu_op_t;

	function automatic mips_funct_t cmd_to_funct(calc_cmd_t c);
		case (c)
			cmd_add: return fn_add;
			cmd_sub: return fn_sub;
			cmd_and: return fn_and;
			cmd_or:  return fn_or;
			cmd_xor: return fn_xor;
			cmd_sll: return fn_sll;
			cmd_srl: return fn_srl;
			default: return fn_sra;
		endcase
	endfunction

	// unknown funct falls back to add
	function automatic alu_op_t funct_to_alu(mips_funct_t f);
		case (f)
			fn_sub:  return alu_sub;
			fn_and:  return alu_and;
			fn_or:   return alu_or;
			fn_xor:  return alu_xor;
			fn_sll:  return alu_sll;
			fn_srl:  return alu_srl;
			fn_sra:  return alu_sra;
			default: return alu_add;
		endcase
	endfunction

endpackage

// ==== key_program.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module key_program import calc_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     run,
	input  logic                     load,
	input  calc_cmd_t                cmd,
	input  logic [1:0]               select,
	input  logic [7:0]               data,
	output logic                     prog_we,
	output logic [`CALC_IMEM_AW-1:0] prog_addr,
	output logic [31:0]              prog_wdata,
	output logic                     core_run_n
);

	prog_state_t state;
	prog_state_t state_next;
	logic [`CALC_IMEM_AW-1:0] wr_cnt;
	logic [1:0] load_sel;
	logic [7:0] load_data;
	// a hi, a lo, b hi, b lo
	logic [7:0] bytes [4];
	logic is_shift;

	always_comb begin
		state_next = state;
		case (state)
			st_reset: state_next = st_idle;
			st_idle: begin
				if (run)
					state_next = st_write;
				else if (load)
					state_next = st_load;
			end
			st_load: state_next = st_idle;
			st_write: begin
				if (wr_cnt == `CALC_IMEM_AW'(`CALC_PROG_LEN - 1))
					state_next = st_run;
			end
			st_run: begin
				if (!run)
					state_next = st_idle;
			end
			default: state_next = st_reset;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_reset;
			wr_cnt <= '0;
			core_run_n <= 1'b0;
		end else begin
			state <= state_next;
			wr_cnt <= (state == st_write) ? wr_cnt + 1'b1 : '0;
			// hold the core from the first write cycle on
			if (state == st_idle && run)
				core_run_n <= 1'b0;
			else if (state == st_run)
				core_run_n <= 1'b1;
		end
	end

	// strobe captures select and data, load state stores the byte
	always_ff @(posedge clk) begin
		if (state == st_idle && load && !run) begin
			load_sel <= select;
			load_data <= data;
		end
		if (state == st_reset) begin
			for (int i = 0; i < 4; i++)
				bytes[i] <= 8'h00;
		end else if (state == st_load) begin
			bytes[load_sel] <= load_data;
		end
	end

	assign is_shift = (cmd == cmd_sll) || (cmd == cmd_srl) || (cmd == cmd_sra);

	assign prog_we = (state == st_write);
	assign prog_addr = wr_cnt;

	always_comb begin
		case (wr_cnt)
			`CALC_IMEM_AW'(0): prog_wdata = {op_addi, 5'd0, 5'd1, bytes[0], bytes[1]};
			`CALC_IMEM_AW'(1): prog_wdata = {op_addi, 5'd0, 5'd2, bytes[2], bytes[3]};
			`CALC_IMEM_AW'(2): begin
				// shifts take r1 as rt and the amount from b's low byte
				if (is_shift)
					prog_wdata = {op_rtype, 5'd0, 5'd1, 5'd3, bytes[3][4:0],
						cmd_to_funct(cmd)};
				else
					prog_wdata = {op_rtype, 5'd1, 5'd2, 5'd3, 5'd0, cmd_to_funct(cmd)};
			end
			default: prog_wdata = {op_j, 26'd3};
		endcase
	end

	a_we_holds_core: assert property (@(posedge clk) disable iff (!rst_n)
		prog_we |-> !core_run_n)
		else $error("program written while the core runs");

endmodule

// ==== imem_arbiter.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module imem_arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     prog_we,
	input  logic [`CALC_IMEM_AW-1:0] prog_addr,
	input  logic [31:0]              prog_wdata,
	input  logic                     fetch_req,
	input  logic [`CALC_IMEM_AW-1:0] fetch_addr,
	output logic                     fetch_gnt,
	output logic [31:0]              fetch_data
);

	logic [31:0] mem [`CALC_IMEM_DEPTH];

	// writer wins, fetch waits
	assign fetch_gnt = fetch_req && !prog_we;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `CALC_IMEM_DEPTH; i++)
				mem[i] <= 32'h0;
		end else if (prog_we) begin
			mem[prog_addr] <= prog_wdata;
		end
	end

	// synchronous read, data one cycle after grant
	always_ff @(posedge clk) begin
		if (fetch_gnt)
			fetch_data <= mem[fetch_addr];
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ns

module alu import calc_pkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	input  alu_op_t     op,
	output logic [31:0] y
);

	always_comb begin
		case (op)
			alu_add: y = a + b;
			alu_sub: y = a - b;
			alu_and: y = a & b;
			alu_or:  y = a | b;
			alu_xor: y = a ^ b;
			// shifts act on rt, as in MIPS
			alu_sll: y = b << shamt;
			alu_srl: y = b >> shamt;
			alu_sra: y = $signed(b) >>> shamt;
			default: y = 32'h0;
		endcase
	end

endmodule

// ==== mips_core.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module mips_core import calc_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     core_run_n,
	input  logic                     fetch_gnt,
	input  logic [31:0]              fetch_data,
	output logic                     fetch_req,
	output logic [`CALC_IMEM_AW-1:0] fetch_addr,
	output logic [31:0]              result,
	output logic                     result_valid
);

	core_state_t state;
	logic [`CALC_IMEM_AW-1:0] pc;
	logic [31:0] regs [32];
	mips_op_t opcode;
	logic wr_en;
	logic [4:0] wr_addr;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	alu_op_t alu_op;
	logic is_jump;
	logic [25:0] pc_next_wide;

	assign fetch_req = core_run_n && (state == cs_fetch);
	assign fetch_addr = pc;

	// decode straight from the registered fetch data
	assign opcode = mips_op_t'(fetch_data[31:26]);

	always_comb begin
		wr_en = 1'b0;
		wr_addr = 5'd0;
		alu_b = regs[fetch_data[20:16]];
		alu_op = alu_add;
		is_jump = 1'b0;
		case (opcode)
			op_addi: begin
				wr_en = 1'b1;
				wr_addr = fetch_data[20:16];
				alu_b = {{16{fetch_data[15]}}, fetch_data[15:0]};
			end
			op_rtype: begin
				wr_en = 1'b1;
				wr_addr = fetch_data[15:11];
				alu_op = funct_to_alu(mips_funct_t'(fetch_data[5:0]));
			end
			op_j: is_jump = 1'b1;
			default: ;
		endcase
	end

	alu u_alu (
		.a     (regs[fetch_data[25:21]]),
		.b     (alu_b),
		.shamt (fetch_data[10:6]),
		.op    (alu_op),
		.y     (alu_y)
	);

	assign pc_next_wide = is_jump ? fetch_data[25:0] : 26'(pc) + 26'd1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cs_fetch;
			pc <= '0;
		end else if (!core_run_n) begin
			state <= cs_fetch;
			pc <= '0;
		end else if (state == cs_fetch) begin
			if (fetch_gnt)
				state <= cs_exec;
		end else begin
			state <= cs_fetch;
			pc <= pc_next_wide[`CALC_IMEM_AW-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (!core_run_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'h0;
		end else if (state == cs_exec && wr_en && wr_addr != 5'd0) begin
			regs[wr_addr] <= alu_y;
		end
	end

	assign result_valid = (state == cs_exec) && wr_en && (wr_addr == 5'd3);
	assign result = alu_y;

	// the program must never jump or step past the end of memory
	a_pc_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		(core_run_n && state == cs_exec) |-> (pc_next_wide < `CALC_IMEM_DEPTH))
		else $error("pc leaves instruction memory");

endmodule

// ==== calc_top.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_top import calc_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,
	input  logic        load,
	input  calc_cmd_t   cmd,
	input  logic [1:0]  select,
	input  logic [7:0]  data,
	output logic [31:0] result,
	output logic        result_valid
);

	logic prog_we;
	logic [`CALC_IMEM_AW-1:0] prog_addr;
	logic [31:0] prog_wdata;
	logic core_run_n;
	logic fetch_req;
	logic fetch_gnt;
	logic [`CALC_IMEM_AW-1:0] fetch_addr;
	logic [31:0] fetch_data;

	key_program u_key_program (
		.clk        (clk),
		.rst_n      (rst_n),
		.run        (run),
		.load       (load),
		.cmd        (cmd),
		.select     (select),
		.data       (data),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_wdata (prog_wdata),
		.core_run_n (core_run_n)
	);

	imem_arbiter u_imem_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.prog_we    (prog_we),
		.prog_addr  (prog_addr),
		.prog_wdata (prog_wdata),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_gnt  (fetch_gnt),
		.fetch_data (fetch_data)
	);

	mips_core u_mips_core (
		.clk          (clk),
		.rst_n        (rst_n),
		.core_run_n   (core_run_n),
		.fetch_gnt    (fetch_gnt),
		.fetch_data   (fetch_data),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.result       (result),
		.result_valid (result_valid)
	);

endmodule

// ==== calc_tb.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_tb import calc_pkg::*; ();

	localparam int RESULT_TIMEOUT = 200;

	logic clk;
	logic rst_n;
	logic run;
	logic load;
	calc_cmd_t cmd;
	logic [1:0] select;
	logic [7:0] data;
	logic [31:0] result;
	logic result_valid;

	// model copy of the bytes: a hi, a lo, b hi, b lo
	logic [7:0] kb [4];
	logic ran;
	int pulse_cnt;
	int order [8];

	calc_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.run          (run),
		.load         (load),
		.cmd          (cmd),
		.select       (select),
		.data         (data),
		.result       (result),
		.result_valid (result_valid)
	);

	always #5 clk = ~clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] expected_r3(input logic [7:0] a_hi, input logic [7:0] a_lo,
		input logic [7:0] b_hi, input logic [7:0] b_lo, input calc_cmd_t c);
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] sh;
		a = {{16{a_hi[7]}}, a_hi, a_lo};
		b = {{16{b_hi[7]}}, b_hi, b_lo};
		sh = b_lo[4:0];
		case (c)
			cmd_add: return a + b;
			cmd_sub: return a - b;
			cmd_and: return a & b;
			cmd_or:  return a | b;
			cmd_xor: return a ^ b;
			cmd_sll: return a << sh;
			cmd_srl: return a >> sh;
			default: return $signed(a) >>> sh;
		endcase
	endfunction

	// pulses seen since run went high
	always @(posedge clk) begin
		if (!run)
			pulse_cnt <= 0;
		else if (result_valid)
			pulse_cnt <= pulse_cnt + 1;
	end

	a_quiet_before_run: assert property (@(posedge clk) disable iff (!rst_n)
		!ran |-> !result_valid)
		else stop_run($sformatf("CHECK FAILED at %0t ns: result_valid before any run", $time));

	a_one_pulse_per_run: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> pulse_cnt == 0)
		else stop_run($sformatf("CHECK FAILED at %0t ns: second result pulse in one run", $time));

	task automatic load_byte(input logic [1:0] sel, input logic [7:0] val);
		@(posedge clk);
		load <= 1'b1;
		select <= sel;
		data <= val;
		@(posedge clk);
		load <= 1'b0;
		@(posedge clk);
	endtask

	// stray load lands while the program is being written
	task automatic run_and_check(input calc_cmd_t c, input bit stray,
		input logic [1:0] stray_sel, input logic [7:0] stray_val);
		logic [31:0] exp;
		bit got;
		exp = expected_r3(kb[0], kb[1], kb[2], kb[3], c);
		got = 1'b0;
		@(posedge clk);
		cmd <= c;
		run <= 1'b1;
		ran <= 1'b1;
		if (stray) begin
			@(posedge clk);
			load <= 1'b1;
			select <= stray_sel;
			data <= stray_val;
			@(posedge clk);
			load <= 1'b0;
		end
		for (int cyc = 0; cyc < RESULT_TIMEOUT && !got; cyc++) begin
			@(negedge clk);
			if (result_valid) begin
				got = 1'b1;
				assert (result == exp)
					else stop_run($sformatf("CHECK FAILED at %0t ns: %s gave %h, expected %h",
						$time, c.name(), result, exp));
			end
		end
		if (!got)
			stop_run($sformatf("the result never arrived within %0d cycles", RESULT_TIMEOUT));
		// core now spins on the jump
		repeat (20) @(posedge clk);
		run <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	initial begin
		int j;
		int tmp;
		logic [1:0] sel;
		logic [7:0] val;
		void'($urandom(65181));
		clk = 1'b0;
		rst_n = 1'b0;
		run = 1'b0;
		load = 1'b0;
		cmd = cmd_add;
		select = 2'd0;
		data = 8'h00;
		ran = 1'b0;
		for (int k = 0; k < 4; k++)
			kb[k] = 8'h00;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (20) @(posedge clk);

		for (int i = 0; i < 8; i++)
			order[i] = i;
		for (int i = 7; i > 0; i--) begin
			j = int'($urandom_range(i, 0));
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end

		// every command once, sign bits alternate between a and b
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 4; k++) begin
				val = 8'($urandom);
				if (k == 0)
					val[7] = i[0];
				if (k == 2)
					val[7] = ~i[0];
				kb[k] = val;
				load_byte(2'(k), val);
			end
			run_and_check(calc_cmd_t'(3'(order[i])), 1'b0, 2'd0, 8'h00);
		end

		// single byte reloads, add and sub show a change in any byte
		for (int i = 0; i < 4; i++) begin
			sel = 2'($urandom_range(3, 0));
			val = kb[sel] ^ 8'($urandom_range(255, 1));
			kb[sel] = val;
			load_byte(sel, val);
			run_and_check(calc_cmd_t'(i[0] ? cmd_sub : cmd_add), 1'b0, 2'd0, 8'h00);
		end

		// load during a run is dropped, then taken in idle
		sel = 2'($urandom_range(3, 0));
		val = kb[sel] ^ 8'($urandom_range(255, 1));
		run_and_check(cmd_xor, 1'b1, sel, val);
		run_and_check(cmd_xor, 1'b0, 2'd0, 8'h00);
		kb[sel] = val;
		load_byte(sel, val);
		run_and_check(cmd_xor, 1'b0, 2'd0, 8'h00);

		$display("test passed");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
calc_pkg.sv
key_program.sv
imem_arbiter.sv
alu.sv
mips_core.sv
calc_top.sv
calc_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module calc_tb -f src.f -o calc_sim
./obj_dir/calc_sim
